//--- design/xpu_pkg.sv
// xpu shared definitions
package xpu_pkg;

    localparam int REG_DATA_WIDTH  = 32;
    localparam int REG_ADDR_WIDTH  = 6;
    localparam int TSF_TIMER_WIDTH = 64;
    localparam int MAC_ADDR_WIDTH  = 48;
    localparam int BYTE_CNT_WIDTH  = 16;

    // 10 MHz core clock
    localparam int CLK_PER_US = 10;

    localparam logic [REG_DATA_WIDTH-1:0] HW_VERSION = 32'h5850_0103;

    // register word indices
    localparam logic [REG_ADDR_WIDTH-1:0] REG_SOFT_RST  = 6'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_TSF_LO    = 6'd2;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_TSF_HI    = 6'd3;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_BAND_CHAN = 6'd4;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_IFS_OVR   = 6'd9;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_MAC_LO    = 6'd30;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_MAC_HI    = 6'd31;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_ADDR2_RB  = 6'd37;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_TSF_RT_LO = 6'd58;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_TSF_RT_HI = 6'd59;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_VERSION   = 6'd63;

    // soft reset bit of the rx parser
    localparam int SOFT_RST_PARSE_BIT = 3;

    localparam logic [3:0] BAND_2G4 = 4'd1;

    // default 802.11 OFDM/ERP times in us
    localparam logic [6:0] PREAMBLE_TIME_US = 7'd20;
    localparam logic [4:0] SYMBOL_TIME_US   = 5'd4;
    localparam logic [4:0] SLOT_SHORT_US    = 5'd9;
    localparam logic [4:0] SLOT_LONG_US     = 5'd20;
    localparam logic [6:0] SIFS_2G4_US      = 7'd10;
    localparam logic [6:0] SIFS_5G_US       = 7'd16;
    localparam logic [6:0] RX_DELAY_2G4_US  = 7'd24;
    localparam logic [6:0] RX_DELAY_5G_US   = 7'd25;

    typedef struct packed {
        logic [REG_DATA_WIDTH-1:0]  soft_rst;
        logic [TSF_TIMER_WIDTH-1:0] tsf_load_val;
        logic                       tsf_load_ctl;
        logic [3:0]                 band;
        logic [7:0]                 channel;
        logic                       erp_short_slot;
        logic [REG_DATA_WIDTH-1:0]  ifs_ovr;
        logic [MAC_ADDR_WIDTH-1:0]  mac_addr;
    } xpu_cfg_t;

    typedef struct packed {
        logic [6:0] preamble_sig_time;
        logic [4:0] ofdm_symbol_time;
        logic [4:0] slot_time;
        logic [6:0] sifs_time;
        logic [6:0] phy_rx_start_delay_time;
    } ifs_times_t;

    // frame control in the low half, duration in the high half
    typedef struct packed {
        logic [15:0] duration;
        logic        order;
        logic        protected_frame;
        logic        more_data;
        logic        power_manage;
        logic        retry;
        logic        more_frag;
        logic        from_ds;
        logic        to_ds;
        logic [3:0]  fc_subtype;
        logic [1:0]  fc_type;
        logic [1:0]  version;
    } fc_fields_t;

    typedef union packed {
        logic [REG_DATA_WIDTH-1:0] raw;
        fc_fields_t                fields;
    } fc_di_u;

    typedef struct packed {
        fc_di_u                    fc;
        logic [MAC_ADDR_WIDTH-1:0] addr1;
        logic [MAC_ADDR_WIDTH-1:0] addr2;
        logic [MAC_ADDR_WIDTH-1:0] addr3;
        logic                      fc_valid;
        logic                      addr1_valid;
        logic                      addr2_valid;
        logic                      addr3_valid;
    } rx_hdr_t;

endpackage

//--- design/xpu_regs.sv
// xpu register bank
`timescale 1ns/100ps

module xpu_regs (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 reg_wr_en_i,
    input  logic                                 reg_rd_en_i,
    input  logic [xpu_pkg::REG_ADDR_WIDTH-1:0]   reg_addr_i,
    input  logic [xpu_pkg::REG_DATA_WIDTH-1:0]   reg_wdata_i,
    input  logic [xpu_pkg::TSF_TIMER_WIDTH-1:0]  tsf_runtime_val_i,
    input  logic [xpu_pkg::MAC_ADDR_WIDTH-1:0]   addr2_i,
    output logic [xpu_pkg::REG_DATA_WIDTH-1:0]   reg_rdata_o,
    output logic                                 reg_rd_valid_o,
    output xpu_pkg::xpu_cfg_t                    cfg_o
);
    import xpu_pkg::*;

    logic [REG_DATA_WIDTH-1:0] soft_rst_q;
    logic [REG_DATA_WIDTH-1:0] tsf_lo_q;
    logic [REG_DATA_WIDTH-1:0] tsf_hi_q;
    logic [REG_DATA_WIDTH-1:0] band_chan_q;
    logic [REG_DATA_WIDTH-1:0] ifs_ovr_q;
    logic [REG_DATA_WIDTH-1:0] mac_lo_q;
    logic [REG_DATA_WIDTH-1:0] mac_hi_q;
    logic [REG_DATA_WIDTH-1:0] rd_mux;
    logic [REG_DATA_WIDTH-1:0] addr2_swap;

    // write side
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            soft_rst_q  <= '0;
            tsf_lo_q    <= '0;
            tsf_hi_q    <= '0;
            band_chan_q <= '0;
            ifs_ovr_q   <= '0;
            mac_lo_q    <= '0;
            mac_hi_q    <= '0;
        end else if (reg_wr_en_i) begin
            case (reg_addr_i)
                REG_SOFT_RST:  soft_rst_q  <= reg_wdata_i;
                REG_TSF_LO:    tsf_lo_q    <= reg_wdata_i;
                REG_TSF_HI:    tsf_hi_q    <= reg_wdata_i;
                REG_BAND_CHAN: band_chan_q <= reg_wdata_i;
                REG_IFS_OVR:   ifs_ovr_q   <= reg_wdata_i;
                REG_MAC_LO:    mac_lo_q    <= reg_wdata_i;
                REG_MAC_HI:    mac_hi_q    <= reg_wdata_i;
                default: ;
            endcase
        end
    end

    // decoded configuration
    always_comb begin
        cfg_o.soft_rst       = soft_rst_q;
        cfg_o.tsf_load_val   = {tsf_hi_q, tsf_lo_q};
        cfg_o.tsf_load_ctl   = tsf_hi_q[REG_DATA_WIDTH-1];
        cfg_o.band           = band_chan_q[19:16];
        cfg_o.channel        = band_chan_q[7:0];
        cfg_o.erp_short_slot = band_chan_q[24];
        cfg_o.ifs_ovr        = ifs_ovr_q;
        cfg_o.mac_addr       = {mac_hi_q[15:0], mac_lo_q};
    end

    // addr2 bytes 2..5 from low to high byte lane
    assign addr2_swap = {addr2_i[47:40], addr2_i[39:32], addr2_i[31:24], addr2_i[23:16]};

    always_comb begin
        case (reg_addr_i)
            REG_SOFT_RST:  rd_mux = soft_rst_q;
            REG_TSF_LO:    rd_mux = tsf_lo_q;
            REG_TSF_HI:    rd_mux = tsf_hi_q;
            REG_BAND_CHAN: rd_mux = band_chan_q;
            REG_IFS_OVR:   rd_mux = ifs_ovr_q;
            REG_MAC_LO:    rd_mux = mac_lo_q;
            REG_MAC_HI:    rd_mux = mac_hi_q;
            REG_ADDR2_RB:  rd_mux = addr2_swap;
            REG_TSF_RT_LO: rd_mux = tsf_runtime_val_i[REG_DATA_WIDTH-1:0];
            REG_TSF_RT_HI: rd_mux = tsf_runtime_val_i[TSF_TIMER_WIDTH-1:REG_DATA_WIDTH];
            REG_VERSION:   rd_mux = HW_VERSION;
            default:       rd_mux = '0;
        endcase
    end

    // read data valid one cycle after the strobe
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            reg_rd_valid_o <= 1'b0;
        end else begin
            reg_rd_valid_o <= reg_rd_en_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reg_rd_en_i) begin
            reg_rdata_o <= rd_mux;
        end
    end

endmodule

//--- design/tsf_timer.sv
// TSF timer
`timescale 1ns/100ps

module tsf_timer (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                tsf_load_ctl_i,
    input  logic [xpu_pkg::TSF_TIMER_WIDTH-1:0] tsf_load_val_i,
    output logic [xpu_pkg::TSF_TIMER_WIDTH-1:0] tsf_runtime_val_o,
    output logic                                tsf_pulse_1m_o
);
    import xpu_pkg::*;

    localparam int PRESCALE_WIDTH = $clog2(CLK_PER_US);

    logic                      load_ctl_d1;
    logic                      load_ctl_d2;
    logic                      load_edge;
    logic [PRESCALE_WIDTH-1:0] prescale_cnt;

    assign load_edge = load_ctl_d1 & ~load_ctl_d2;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            load_ctl_d1       <= 1'b0;
            load_ctl_d2       <= 1'b0;
            prescale_cnt      <= '0;
            tsf_pulse_1m_o    <= 1'b0;
            tsf_runtime_val_o <= '0;
        end else begin
            load_ctl_d1 <= tsf_load_ctl_i;
            load_ctl_d2 <= load_ctl_d1;
            // free running 1 us prescaler
            if (prescale_cnt == PRESCALE_WIDTH'(CLK_PER_US - 1)) begin
                prescale_cnt   <= '0;
                tsf_pulse_1m_o <= 1'b1;
            end else begin
                prescale_cnt   <= prescale_cnt + 1'b1;
                tsf_pulse_1m_o <= 1'b0;
            end
            if (load_edge) begin
                tsf_runtime_val_o <= tsf_load_val_i;
            end else if (tsf_pulse_1m_o) begin
                tsf_runtime_val_o <= tsf_runtime_val_o + 1'b1;
            end
        end
    end

endmodule

//--- design/ifs_timing.sv
// interframe and slot times
`timescale 1ns/100ps

module ifs_timing (
    input  logic [3:0]                         band_i,
    input  logic                               erp_short_slot_i,
    input  logic [xpu_pkg::REG_DATA_WIDTH-1:0] ifs_ovr_i,
    output xpu_pkg::ifs_times_t                ifs_times_o
);
    import xpu_pkg::*;

    logic is_2g4;

    assign is_2g4 = (band_i == BAND_2G4);

    always_comb begin
        if (ifs_ovr_i[31]) begin
            // software supplies every time
            ifs_times_o.preamble_sig_time       = ifs_ovr_i[30:24];
            ifs_times_o.ofdm_symbol_time        = ifs_ovr_i[23:19];
            ifs_times_o.slot_time               = ifs_ovr_i[18:14];
            ifs_times_o.sifs_time               = ifs_ovr_i[13:7];
            ifs_times_o.phy_rx_start_delay_time = ifs_ovr_i[6:0];
        end else begin
            ifs_times_o.preamble_sig_time = PREAMBLE_TIME_US;
            ifs_times_o.ofdm_symbol_time  = SYMBOL_TIME_US;
            if (is_2g4) begin
                // long ERP slot unless short slot is on
                ifs_times_o.slot_time               = erp_short_slot_i ? SLOT_SHORT_US
                                                                       : SLOT_LONG_US;
                ifs_times_o.sifs_time               = SIFS_2G4_US;
                ifs_times_o.phy_rx_start_delay_time = RX_DELAY_2G4_US;
            end else begin
                ifs_times_o.slot_time               = SLOT_SHORT_US;
                ifs_times_o.sifs_time               = SIFS_5G_US;
                ifs_times_o.phy_rx_start_delay_time = RX_DELAY_5G_US;
            end
        end
    end

endmodule

//--- design/phy_rx_parse.sv
// received MAC header parser
`timescale 1ns/100ps

module phy_rx_parse (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               soft_rst_i,
    input  logic                               pkt_header_valid_strobe_i,
    input  logic                               byte_in_strobe_i,
    input  logic [7:0]                         byte_in_i,
    input  logic [xpu_pkg::BYTE_CNT_WIDTH-1:0] byte_count_i,
    input  logic [xpu_pkg::MAC_ADDR_WIDTH-1:0] self_mac_addr_i,
    output xpu_pkg::rx_hdr_t                   rx_hdr_o,
    output logic                               pkt_for_me_o
);
    import xpu_pkg::*;

    logic                      clear;
    logic [MAC_ADDR_WIDTH-1:0] addr1_next;

    assign clear = !rst_n_i || soft_rst_i || pkt_header_valid_strobe_i;

    // addr1 as it stands once the current byte is shifted in
    assign addr1_next = {byte_in_i, rx_hdr_o.addr1[MAC_ADDR_WIDTH-1:8]};

    always_ff @(posedge clk_i) begin
        if (clear) begin
            rx_hdr_o     <= '0;
            pkt_for_me_o <= 1'b0;
        end else if (byte_in_strobe_i) begin
            // first byte ends up in the lowest bits of each field
            if (byte_count_i <= 16'd3) begin
                rx_hdr_o.fc.raw <= {byte_in_i, rx_hdr_o.fc.raw[REG_DATA_WIDTH-1:8]};
                if (byte_count_i == 16'd3) begin
                    rx_hdr_o.fc_valid <= 1'b1;
                end
            end else if (byte_count_i <= 16'd9) begin
                rx_hdr_o.addr1 <= addr1_next;
                if (byte_count_i == 16'd9) begin
                    rx_hdr_o.addr1_valid <= 1'b1;
                    pkt_for_me_o         <= (addr1_next == self_mac_addr_i);
                end
            end else if (byte_count_i <= 16'd15) begin
                rx_hdr_o.addr2 <= {byte_in_i, rx_hdr_o.addr2[MAC_ADDR_WIDTH-1:8]};
                if (byte_count_i == 16'd15) begin
                    rx_hdr_o.addr2_valid <= 1'b1;
                end
            end else if (byte_count_i <= 16'd21) begin
                rx_hdr_o.addr3 <= {byte_in_i, rx_hdr_o.addr3[MAC_ADDR_WIDTH-1:8]};
                if (byte_count_i == 16'd21) begin
                    rx_hdr_o.addr3_valid <= 1'b1;
                end
            end
        end
    end

endmodule

//--- design/xpu.sv
// xpu top level
`timescale 1ns/100ps

module xpu (
    input  logic                                s00_axi_aclk_i,
    input  logic                                rst_n_i,
    input  logic                                reg_wr_en_i,
    input  logic                                reg_rd_en_i,
    input  logic [xpu_pkg::REG_ADDR_WIDTH-1:0]  reg_addr_i,
    input  logic [xpu_pkg::REG_DATA_WIDTH-1:0]  reg_wdata_i,
    output logic [xpu_pkg::REG_DATA_WIDTH-1:0]  reg_rdata_o,
    output logic                                reg_rd_valid_o,
    input  logic                                pkt_header_valid_strobe_i,
    input  logic                                byte_in_strobe_i,
    input  logic [7:0]                          byte_in_i,
    input  logic [xpu_pkg::BYTE_CNT_WIDTH-1:0]  byte_count_i,
    output logic [xpu_pkg::TSF_TIMER_WIDTH-1:0] tsf_runtime_val_o,
    output logic                                tsf_pulse_1m_o,
    output logic [3:0]                          band_o,
    output logic [7:0]                          channel_o,
    output logic [xpu_pkg::MAC_ADDR_WIDTH-1:0]  mac_addr_o,
    output xpu_pkg::ifs_times_t                 ifs_times_o,
    output logic [xpu_pkg::REG_DATA_WIDTH-1:0]  fc_di_o,
    output logic                                fc_di_valid_o,
    output logic [1:0]                          fc_type_o,
    output logic [3:0]                          fc_subtype_o,
    output logic [15:0]                         duration_o,
    output logic [xpu_pkg::MAC_ADDR_WIDTH-1:0]  addr1_o,
    output logic                                addr1_valid_o,
    output logic [xpu_pkg::MAC_ADDR_WIDTH-1:0]  addr2_o,
    output logic                                addr2_valid_o,
    output logic [xpu_pkg::MAC_ADDR_WIDTH-1:0]  addr3_o,
    output logic                                addr3_valid_o,
    output logic                                pkt_for_me_o
);
    import xpu_pkg::*;

    xpu_cfg_t cfg;
    rx_hdr_t  rx_hdr;

    xpu_regs i_xpu_regs (
        .clk_i             (s00_axi_aclk_i),
        .rst_n_i           (rst_n_i),
        .reg_wr_en_i       (reg_wr_en_i),
        .reg_rd_en_i       (reg_rd_en_i),
        .reg_addr_i        (reg_addr_i),
        .reg_wdata_i       (reg_wdata_i),
        .tsf_runtime_val_i (tsf_runtime_val_o),
        .addr2_i           (rx_hdr.addr2),
        .reg_rdata_o       (reg_rdata_o),
        .reg_rd_valid_o    (reg_rd_valid_o),
        .cfg_o             (cfg)
    );

    tsf_timer i_tsf_timer (
        .clk_i             (s00_axi_aclk_i),
        .rst_n_i           (rst_n_i),
        .tsf_load_ctl_i    (cfg.tsf_load_ctl),
        .tsf_load_val_i    (cfg.tsf_load_val),
        .tsf_runtime_val_o (tsf_runtime_val_o),
        .tsf_pulse_1m_o    (tsf_pulse_1m_o)
    );

    ifs_timing i_ifs_timing (
        .band_i           (cfg.band),
        .erp_short_slot_i (cfg.erp_short_slot),
        .ifs_ovr_i        (cfg.ifs_ovr),
        .ifs_times_o      (ifs_times_o)
    );

    phy_rx_parse i_phy_rx_parse (
        .clk_i                     (s00_axi_aclk_i),
        .rst_n_i                   (rst_n_i),
        .soft_rst_i                (cfg.soft_rst[SOFT_RST_PARSE_BIT]),
        .pkt_header_valid_strobe_i (pkt_header_valid_strobe_i),
        .byte_in_strobe_i          (byte_in_strobe_i),
        .byte_in_i                 (byte_in_i),
        .byte_count_i              (byte_count_i),
        .self_mac_addr_i           (cfg.mac_addr),
        .rx_hdr_o                  (rx_hdr),
        .pkt_for_me_o              (pkt_for_me_o)
    );

    assign band_o        = cfg.band;
    assign channel_o     = cfg.channel;
    assign mac_addr_o    = cfg.mac_addr;

    // side channel gets the raw word, decoders get the fields
    assign fc_di_o       = rx_hdr.fc.raw;
    assign fc_di_valid_o = rx_hdr.fc_valid;
    assign fc_type_o     = rx_hdr.fc.fields.fc_type;
    assign fc_subtype_o  = rx_hdr.fc.fields.fc_subtype;
    assign duration_o    = rx_hdr.fc.fields.duration;
    assign addr1_o       = rx_hdr.addr1;
    assign addr1_valid_o = rx_hdr.addr1_valid;
    assign addr2_o       = rx_hdr.addr2;
    assign addr2_valid_o = rx_hdr.addr2_valid;
    assign addr3_o       = rx_hdr.addr3;
    assign addr3_valid_o = rx_hdr.addr3_valid;

endmodule

//--- verif/tb_clk_gen.sv
// testbench clock and reset
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // reset held for five cycles, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

//--- verif/tb_xpu.sv
// xpu testbench
`timescale 1ns/100ps

module tb_xpu;
    import xpu_pkg::*;

    localparam int OP_WRITE  = 0;
    localparam int OP_READ   = 1;
    localparam int OP_FRAME  = 2;
    localparam int OP_WAIT   = 3;
    localparam int OP_CHECK  = 4;
    localparam int OP_STROBE = 5;
    localparam int OP_TSF    = 6;

    // output selectors for check entries
    localparam logic [5:0] SEL_STATUS  = 6'd0;
    localparam logic [5:0] SEL_IFS     = 6'd1;
    localparam logic [5:0] SEL_MAC     = 6'd2;
    localparam logic [5:0] SEL_BAND    = 6'd3;
    localparam logic [5:0] SEL_CHAN    = 6'd4;
    localparam logic [5:0] SEL_FC      = 6'd5;
    localparam logic [5:0] SEL_TYPE    = 6'd6;
    localparam logic [5:0] SEL_SUBTYPE = 6'd7;
    localparam logic [5:0] SEL_DUR     = 6'd8;
    localparam logic [5:0] SEL_ADDR1   = 6'd9;
    localparam logic [5:0] SEL_ADDR2   = 6'd10;
    localparam logic [5:0] SEL_ADDR3   = 6'd11;
    localparam logic [5:0] SEL_VALID   = 6'd12;
    localparam logic [5:0] SEL_FOR_ME  = 6'd13;
    localparam logic [5:0] SEL_TSF_HI  = 6'd14;

    logic        clk;
    logic        rst_n;
    logic        reg_wr_en;
    logic        reg_rd_en;
    logic [5:0]  reg_addr;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;
    logic        reg_rd_valid;
    logic        hdr_strobe;
    logic        byte_strobe;
    logic [7:0]  byte_val;
    logic [15:0] byte_cnt;
    logic [63:0] tsf_val;
    logic        tsf_pulse;
    logic [3:0]  band;
    logic [7:0]  channel;
    logic [47:0] mac_addr;
    ifs_times_t  ifs_times;
    logic [31:0] fc_di;
    logic        fc_di_valid;
    logic [1:0]  fc_type;
    logic [3:0]  fc_subtype;
    logic [15:0] duration;
    logic [47:0] addr1;
    logic        addr1_valid;
    logic [47:0] addr2;
    logic        addr2_valid;
    logic [47:0] addr3;
    logic        addr3_valid;
    logic        pkt_for_me;

    // stimulus table
    string       tbl_name[$];
    int          tbl_op[$];
    logic [5:0]  tbl_addr[$];
    logic [31:0] tbl_data[$];
    logic [63:0] tbl_expect[$];
    int          table_len = 0;
    logic [7:0]  frame_bytes [3][22];

    tb_clk_gen i_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    xpu i_dut (
        .s00_axi_aclk_i            (clk),
        .rst_n_i                   (rst_n),
        .reg_wr_en_i               (reg_wr_en),
        .reg_rd_en_i               (reg_rd_en),
        .reg_addr_i                (reg_addr),
        .reg_wdata_i               (reg_wdata),
        .reg_rdata_o               (reg_rdata),
        .reg_rd_valid_o            (reg_rd_valid),
        .pkt_header_valid_strobe_i (hdr_strobe),
        .byte_in_strobe_i          (byte_strobe),
        .byte_in_i                 (byte_val),
        .byte_count_i              (byte_cnt),
        .tsf_runtime_val_o         (tsf_val),
        .tsf_pulse_1m_o            (tsf_pulse),
        .band_o                    (band),
        .channel_o                 (channel),
        .mac_addr_o                (mac_addr),
        .ifs_times_o               (ifs_times),
        .fc_di_o                   (fc_di),
        .fc_di_valid_o             (fc_di_valid),
        .fc_type_o                 (fc_type),
        .fc_subtype_o              (fc_subtype),
        .duration_o                (duration),
        .addr1_o                   (addr1),
        .addr1_valid_o             (addr1_valid),
        .addr2_o                   (addr2),
        .addr2_valid_o             (addr2_valid),
        .addr3_o                   (addr3),
        .addr3_valid_o             (addr3_valid),
        .pkt_for_me_o              (pkt_for_me)
    );

    task automatic add_entry(input string name, input int op, input logic [5:0] addr,
                             input logic [31:0] data, input logic [63:0] expected);
        tbl_name.push_back(name);
        tbl_op.push_back(op);
        tbl_addr.push_back(addr);
        tbl_data.push_back(data);
        tbl_expect.push_back(expected);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // 802.11 OFDM/ERP defaults, or the software word when bit 31 is set
    function automatic logic [30:0] ifs_expect(input logic [31:0] band_chan,
                                               input logic [31:0] ovr);
        logic [4:0] slot;
        logic [6:0] sifs;
        logic [6:0] rx_delay;
        if (ovr[31]) begin
            return ovr[30:0];
        end
        if (band_chan[19:16] == 4'd1) begin
            slot     = band_chan[24] ? 5'd9 : 5'd20;
            sifs     = 7'd10;
            rx_delay = 7'd24;
        end else begin
            slot     = 5'd9;
            sifs     = 7'd16;
            rx_delay = 7'd25;
        end
        return {7'd20, 5'd4, slot, sifs, rx_delay};
    endfunction

    function automatic logic [63:0] dut_output(input logic [5:0] sel);
        case (sel)
            SEL_STATUS:  return {57'h0, tsf_pulse, reg_rd_valid, pkt_for_me,
                                 fc_di_valid, addr1_valid, addr2_valid, addr3_valid};
            SEL_IFS:     return {33'h0, ifs_times};
            SEL_MAC:     return {16'h0, mac_addr};
            SEL_BAND:    return {60'h0, band};
            SEL_CHAN:    return {56'h0, channel};
            SEL_FC:      return {32'h0, fc_di};
            SEL_TYPE:    return {62'h0, fc_type};
            SEL_SUBTYPE: return {60'h0, fc_subtype};
            SEL_DUR:     return {48'h0, duration};
            SEL_ADDR1:   return {16'h0, addr1};
            SEL_ADDR2:   return {16'h0, addr2};
            SEL_ADDR3:   return {16'h0, addr3};
            SEL_VALID:   return {60'h0, fc_di_valid, addr1_valid, addr2_valid, addr3_valid};
            SEL_FOR_ME:  return {63'h0, pkt_for_me};
            SEL_TSF_HI:  return {32'h0, tsf_val[63:32]};
            default:     return 64'h0;
        endcase
    endfunction

    task automatic write_reg(input logic [5:0] addr, input logic [31:0] data);
        @(negedge clk);
        reg_wr_en = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr_en = 1'b0;
    endtask

    task automatic read_reg(input logic [5:0] addr, output logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        reg_rd_en = 1'b1;
        reg_addr  = addr;
        @(negedge clk);
        reg_rd_en = 1'b0;
        while (!reg_rd_valid && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!reg_rd_valid) begin
            $display("register read of index %0d never returned valid data", addr);
            $display("Test failed");
            $fatal(1);
        end
        data = reg_rdata;
    endtask

    task automatic send_frame(input int idx, input int len);
        for (int i = 0; i < len; i++) begin
            @(negedge clk);
            byte_strobe = 1'b1;
            byte_val    = frame_bytes[idx][i];
            byte_cnt    = 16'(i);
            @(negedge clk);
            byte_strobe = 1'b0;
        end
    endtask

    task automatic pulse_header_strobe();
        @(negedge clk);
        hdr_strobe = 1'b1;
        @(negedge clk);
        hdr_strobe = 1'b0;
    endtask

    // two readings of the low TSF word, strobes exactly 100 cycles apart
    task automatic measure_tsf(input string name, input logic [31:0] load_lo);
        logic [31:0] first;
        logic [31:0] second;
        read_reg(REG_TSF_RT_LO, first);
        repeat (98) @(negedge clk);
        read_reg(REG_TSF_RT_LO, second);
        check_value({name, " in range"}, 64'h1,
                    64'(first >= load_lo && first <= load_lo + 32'd2));
        check_value({name, " step"}, 64'd10, 64'(second - first));
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        logic [47:0] own_mac;
        logic [31:0] mac_hi_word;
        logic [31:0] bc_2g_long;
        logic [31:0] bc_2g_short;
        logic [31:0] bc_5g;
        logic [31:0] ovr_off;
        logic [31:0] ovr_on;
        logic [31:0] tsf_lo;
        logic [31:0] tsf_hi;
        logic [31:0] fc;
        logic [47:0] a1;
        logic [47:0] a2;
        logic [47:0] a3;
        rnd         = $urandom;
        own_mac     = {rnd[15:0], $urandom};
        mac_hi_word = {rnd[31:16], own_mac[47:32]};
        bc_2g_long  = 32'h0001_0006;
        bc_2g_short = 32'h0101_000b;
        bc_5g       = 32'h0002_0024;
        ovr_off     = $urandom & 32'h7fff_ffff;
        ovr_on      = $urandom | 32'h8000_0000;
        // low half kept clear of a carry into the high word
        tsf_lo      = $urandom & 32'h7fff_ffff;
        tsf_hi      = $urandom & 32'h7fff_ffff;
        for (int f = 0; f < 3; f++) begin
            for (int i = 0; i < 22; i++) begin
                frame_bytes[f][i] = 8'($urandom);
            end
        end
        // frame 0 is addressed to us, frame 1 misses by one bit
        for (int i = 0; i < 6; i++) begin
            frame_bytes[0][4 + i] = own_mac[8*i +: 8];
            frame_bytes[1][4 + i] = own_mac[8*i +: 8];
        end
        frame_bytes[1][4] = own_mac[7:0] ^ 8'h01;
        for (int i = 0; i < 4; i++) begin
            fc[8*i +: 8] = frame_bytes[0][i];
        end
        for (int i = 0; i < 6; i++) begin
            a1[8*i +: 8] = frame_bytes[0][4 + i];
            a2[8*i +: 8] = frame_bytes[0][10 + i];
            a3[8*i +: 8] = frame_bytes[0][16 + i];
        end

        add_entry("reset state", OP_CHECK, SEL_STATUS, 32'h0, 64'h0);
        add_entry("write mac lo", OP_WRITE, REG_MAC_LO, own_mac[31:0], 64'h0);
        add_entry("write mac hi", OP_WRITE, REG_MAC_HI, mac_hi_word, 64'h0);
        add_entry("read mac lo", OP_READ, REG_MAC_LO, 32'h0, {32'h0, own_mac[31:0]});
        add_entry("read mac hi", OP_READ, REG_MAC_HI, 32'h0, {32'h0, mac_hi_word});
        add_entry("mac output", OP_CHECK, SEL_MAC, 32'h0, {16'h0, own_mac});
        add_entry("write band 2g4 long", OP_WRITE, REG_BAND_CHAN, bc_2g_long, 64'h0);
        add_entry("read band chan", OP_READ, REG_BAND_CHAN, 32'h0, {32'h0, bc_2g_long});
        add_entry("band output", OP_CHECK, SEL_BAND, 32'h0, 64'd1);
        add_entry("channel output", OP_CHECK, SEL_CHAN, 32'h0, 64'd6);
        add_entry("write ifs ovr off", OP_WRITE, REG_IFS_OVR, ovr_off, 64'h0);
        add_entry("read ifs ovr off", OP_READ, REG_IFS_OVR, 32'h0, {32'h0, ovr_off});
        add_entry("ifs 2g4 long slot", OP_CHECK, SEL_IFS, 32'h0,
                  {33'h0, ifs_expect(bc_2g_long, ovr_off)});
        add_entry("write band 2g4 short", OP_WRITE, REG_BAND_CHAN, bc_2g_short, 64'h0);
        add_entry("ifs 2g4 short slot", OP_CHECK, SEL_IFS, 32'h0,
                  {33'h0, ifs_expect(bc_2g_short, ovr_off)});
        add_entry("write band 5g", OP_WRITE, REG_BAND_CHAN, bc_5g, 64'h0);
        add_entry("read band 5g", OP_READ, REG_BAND_CHAN, 32'h0, {32'h0, bc_5g});
        add_entry("band 5g output", OP_CHECK, SEL_BAND, 32'h0, 64'd2);
        add_entry("channel 5g output", OP_CHECK, SEL_CHAN, 32'h0, 64'h24);
        add_entry("ifs 5g", OP_CHECK, SEL_IFS, 32'h0, {33'h0, ifs_expect(bc_5g, ovr_off)});
        add_entry("write ifs ovr on", OP_WRITE, REG_IFS_OVR, ovr_on, 64'h0);
        add_entry("read ifs ovr on", OP_READ, REG_IFS_OVR, 32'h0, {32'h0, ovr_on});
        add_entry("ifs override", OP_CHECK, SEL_IFS, 32'h0, {33'h0, ifs_expect(bc_5g, ovr_on)});
        add_entry("read version", OP_READ, REG_VERSION, 32'h0, {32'h0, HW_VERSION});
        add_entry("read unmapped", OP_READ, 6'd20, 32'h0, 64'h0);
        add_entry("write tsf lo", OP_WRITE, REG_TSF_LO, tsf_lo, 64'h0);
        add_entry("write tsf hi", OP_WRITE, REG_TSF_HI, tsf_hi, 64'h0);
        add_entry("load tsf", OP_WRITE, REG_TSF_HI, tsf_hi | 32'h8000_0000, 64'h0);
        add_entry("tsf settle", OP_WAIT, 6'd0, 32'd3, 64'h0);
        add_entry("tsf count", OP_TSF, 6'd0, tsf_lo, 64'h0);
        add_entry("read tsf hi", OP_READ, REG_TSF_RT_HI, 32'h0,
                  {32'h0, tsf_hi | 32'h8000_0000});
        add_entry("tsf output hi", OP_CHECK, SEL_TSF_HI, 32'h0,
                  {32'h0, tsf_hi | 32'h8000_0000});
        add_entry("frame for me", OP_FRAME, 6'd22, 32'd0, 64'h0);
        add_entry("fc word", OP_CHECK, SEL_FC, 32'h0, {32'h0, fc});
        add_entry("fc type", OP_CHECK, SEL_TYPE, 32'h0, {62'h0, fc[3:2]});
        add_entry("fc subtype", OP_CHECK, SEL_SUBTYPE, 32'h0, {60'h0, fc[7:4]});
        add_entry("duration", OP_CHECK, SEL_DUR, 32'h0, {48'h0, fc[31:16]});
        add_entry("addr1", OP_CHECK, SEL_ADDR1, 32'h0, {16'h0, a1});
        add_entry("addr2", OP_CHECK, SEL_ADDR2, 32'h0, {16'h0, a2});
        add_entry("addr3", OP_CHECK, SEL_ADDR3, 32'h0, {16'h0, a3});
        add_entry("all fields valid", OP_CHECK, SEL_VALID, 32'h0, 64'hf);
        add_entry("pkt for me", OP_CHECK, SEL_FOR_ME, 32'h0, 64'h1);
        // byte 2 of addr2 lands in the low lane
        add_entry("addr2 readback", OP_READ, REG_ADDR2_RB, 32'h0,
                  {32'h0, frame_bytes[0][15], frame_bytes[0][14],
                   frame_bytes[0][13], frame_bytes[0][12]});
        add_entry("header strobe", OP_STROBE, 6'd0, 32'h0, 64'h0);
        add_entry("valid cleared", OP_CHECK, SEL_VALID, 32'h0, 64'h0);
        add_entry("for me cleared", OP_CHECK, SEL_FOR_ME, 32'h0, 64'h0);
        add_entry("frame for other", OP_FRAME, 6'd22, 32'd1, 64'h0);
        add_entry("other fields valid", OP_CHECK, SEL_VALID, 32'h0, 64'hf);
        add_entry("not for me", OP_CHECK, SEL_FOR_ME, 32'h0, 64'h0);
        add_entry("header strobe 2", OP_STROBE, 6'd0, 32'h0, 64'h0);
        add_entry("short frame", OP_FRAME, 6'd12, 32'd2, 64'h0);
        add_entry("short frame valid", OP_CHECK, SEL_VALID, 32'h0, 64'hc);
        table_len = tbl_name.size();
    endtask

    // watchdog
    initial begin
        wait (table_len > 0);
        repeat (table_len * 200) @(posedge clk);
        $display("watchdog expired before the table finished");
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        logic [31:0] rd_word;
        reg_wr_en   = 1'b0;
        reg_rd_en   = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        hdr_strobe  = 1'b0;
        byte_strobe = 1'b0;
        byte_val    = '0;
        byte_cnt    = '0;
        void'($urandom(32'h46fd6601));
        build_table();
        wait (rst_n === 1'b1);
        for (int k = 0; k < table_len; k++) begin
            case (tbl_op[k])
                OP_WRITE:  write_reg(tbl_addr[k], tbl_data[k]);
                OP_READ: begin
                    read_reg(tbl_addr[k], rd_word);
                    check_value(tbl_name[k], tbl_expect[k], {32'h0, rd_word});
                end
                OP_FRAME:  send_frame(int'(tbl_data[k]), int'(tbl_addr[k]));
                OP_WAIT:   repeat (tbl_data[k]) @(negedge clk);
                OP_CHECK: begin
                    @(negedge clk);
                    check_value(tbl_name[k], tbl_expect[k], dut_output(tbl_addr[k]));
                end
                OP_STROBE: pulse_header_strobe();
                OP_TSF:    measure_tsf(tbl_name[k], tbl_data[k]);
                default:   ;
            endcase
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- project.f
design/xpu_pkg.sv
design/xpu_regs.sv
design/tsf_timer.sv
design/ifs_timing.sv
design/phy_rx_parse.sv
design/xpu.sv
verif/tb_clk_gen.sv
verif/tb_xpu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the xpu testbench with Verilator
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module tb_xpu -f project.f -o tb_xpu_sim \
    && ./obj_dir/tb_xpu_sim | grep -q "Test completed successfully" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
